// File: all.f
+incdir+design
design/pe_data_pkg.sv
design/readout_pkg.sv
design/feed_if.sv
design/operand_skew.sv
design/pe.sv
design/pe_array.sv
design/channel_readout.sv
design/sa_top.sv
verification/sa_assert.sv
verification/sa_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the systolic array testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module sa_tb --Mdir obj_dir -o sa_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sa_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
exit 1

// File: verification/sa_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "sa_params.svh"

module sa_tb;
    import readout_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_CHANNELS = 4;
    localparam int MAX_DATA     = 40;
    // drain time after the last live operand
    localparam int FLUSH        = 2*`SA_ROWS + 4;
    // full counter ring plus one to see row 0 again
    localparam int READ_STROBES = (1 << `SA_ROW_CNT_W) + 1;
    localparam int CHAN_CYCLES  = 1 + 4 + MAX_DATA + FLUSH + READ_STROBES;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CHANNELS*CHAN_CYCLES + 20) * CLK_PERIOD;
    localparam int HALF_W       = `SA_COLS * 2 * `SA_ACC18_W;

    logic                         clk;
    logic                         channel_out_reset;
    logic                         en;
    sa_mode_e                     mode;
    logic                         acc_clear;
    logic                         channel_out_en;
    logic [8*`SA_ROWS-1:0]        row_in;
    logic [16*`SA_COLS-1:0]       column_in;
    logic [SA_OUT_W-1:0]          out;

    // reference sums, [k] or [b][k] as in the cell
    logic [`SA_ACC88_W-1:0] acc88 [`SA_ROWS][`SA_COLS][2];
    logic [`SA_ACC18_W-1:0] sum18 [`SA_ROWS][`SA_COLS][2][2];

    integer   seed;
    int       errors;
    int       checks;
    // expected readout counter, starts idle
    int       rd_ptr;
    int       n_data;
    sa_mode_e chan_mode;

    sa_top dut_i (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .en                (en),
        .mode              (mode),
        .acc_clear         (acc_clear),
        .channel_out_en    (channel_out_en),
        .row_in            (row_in),
        .column_in         (column_in),
        .out               (out)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [SA_OUT_W-1:0] got,
                               input logic [SA_OUT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // inputs change just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // idle readout must show zero
    task automatic idle_cycle();
        if (rd_ptr >= `SA_ROWS) begin
            check_value("out", out, '0);
        end
        next_cycle();
    endtask

    task automatic clear_model();
        for (int i = 0; i < `SA_ROWS; i++) begin
            for (int j = 0; j < `SA_COLS; j++) begin
                for (int k = 0; k < 2; k++) begin
                    acc88[i][j][k]    = '0;
                    sum18[i][j][0][k] = '0;
                    sum18[i][j][1][k] = '0;
                end
            end
        end
    endtask

    // every cell sees every issued weight and pixel once
    task automatic model_step();
        logic signed [7:0]             w;
        logic signed [7:0]             px [2];
        logic signed [`SA_ACC88_W-1:0] prod;
        logic [`SA_ACC18_W-1:0]        ext;
        for (int i = 0; i < `SA_ROWS; i++) begin
            w = row_in[8*i +: 8];
            for (int j = 0; j < `SA_COLS; j++) begin
                px[0] = column_in[16*j +: 8];
                px[1] = column_in[16*j+8 +: 8];
                for (int k = 0; k < 2; k++) begin
                    if (mode == MODE_8X8) begin
                        prod = w * px[k];
                        acc88[i][j][k] = acc88[i][j][k] + prod;
                    end else begin
                        ext = {{(`SA_ACC18_W-8){px[k][7]}}, px[k]};
                        for (int b = 0; b < 2; b++) begin
                            if (w[b]) begin
                                sum18[i][j][b][k] = sum18[i][j][b][k] + ext;
                            end
                        end
                    end
                end
            end
        end
    endtask

    // lo then hi per column in 8x8, weight bit selects the half in 1x8
    function automatic logic [SA_OUT_W-1:0] expected_out(input int row, input sa_mode_e m);
        logic [SA_OUT_W-1:0] v;
        v = '0;
        if (row < `SA_ROWS) begin
            for (int j = 0; j < `SA_COLS; j++) begin
                for (int k = 0; k < 2; k++) begin
                    if (m == MODE_8X8) begin
                        v[2*`SA_ACC88_W*j + `SA_ACC88_W*k +: `SA_ACC88_W] = acc88[row][j][k];
                    end else begin
                        for (int b = 0; b < 2; b++) begin
                            v[b*HALF_W + 2*`SA_ACC18_W*j + `SA_ACC18_W*k +: `SA_ACC18_W] =
                                sum18[row][j][b][k];
                        end
                    end
                end
            end
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // channel sequence
    ////////////////////////////////////////////////////////////
    task automatic run_channel(input sa_mode_e m, input int n);
        // mode and clear together, then let the clear land
        mode      = m;
        acc_clear = 1'b1;
        next_cycle();
        acc_clear = 1'b0;
        clear_model();
        repeat (4) idle_cycle();
        // random operands, en low about one cycle in four
        for (int c = 0; c < n; c++) begin
            en = ($random(seed) & 3) != 0;
            for (int i = 0; i < `SA_ROWS; i++) begin
                row_in[8*i +: 8] = 8'($random(seed));
            end
            for (int j = 0; j < `SA_COLS; j++) begin
                column_in[16*j +: 16] = 16'($random(seed));
            end
            if (en) begin
                model_step();
            end
            idle_cycle();
        end
        en = 1'b0;
        repeat (FLUSH) idle_cycle();
        // walk the whole counter ring
        check_value("out", out, expected_out(rd_ptr, m));
        repeat (READ_STROBES) begin
            channel_out_en = 1'b1;
            next_cycle();
            channel_out_en = 1'b0;
            rd_ptr = (rd_ptr + 1) % (1 << `SA_ROW_CNT_W);
            check_value("out", out, expected_out(rd_ptr, m));
        end
    endtask

    // run bound by channel count times channel length
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before the channel sequence finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk               = 1'b0;
        channel_out_reset = 1'b1;
        en                = 1'b0;
        mode              = MODE_8X8;
        acc_clear         = 1'b0;
        channel_out_en    = 1'b0;
        row_in            = '0;
        column_in         = '0;
        seed              = 32'h5364ab47;
        errors            = 0;
        checks            = 0;
        rd_ptr            = (1 << `SA_ROW_CNT_W) - 1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        channel_out_reset = 1'b0;

        // modes alternate, lengths 20 to 40
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            chan_mode = (ch % 2 == 1) ? MODE_1X8 : MODE_8X8;
            n_data    = 20 + int'((32'($random(seed)) & 32'h7fff_ffff) % 21);
            run_channel(chan_mode, n_data);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/sa_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "sa_params.svh"

module sa_assert (
    input logic                             clk,
    input logic                             channel_out_reset,
    input logic [`SA_ROW_CNT_W-1:0]         row_counter,
    input logic [`SA_ROW_CNT_W-1:0]         row_sel,
    input logic [readout_pkg::SA_OUT_W-1:0] out
);
    // first counter code past the last row
    localparam logic [`SA_ROW_CNT_W-1:0] ROW_LIMIT = `SA_ROW_CNT_W'(`SA_ROWS);

    // idle codes read as an all zero word
    idle_out_zero: assert property (@(posedge clk) disable iff (channel_out_reset)
        (row_counter >= ROW_LIMIT) |-> (out == '0))
        else $error("readout word not zero while the row counter is idle");

    // array access never leaves the grid
    row_sel_range: assert property (@(posedge clk) disable iff (channel_out_reset)
        (row_sel < ROW_LIMIT))
        else $error("row select points past the last array row");

    // reset parks the counter on the idle code
    reset_idle: assert property (@(posedge clk)
        channel_out_reset |=> (row_counter == '1))
        else $error("row counter not all ones after reset");

endmodule

bind channel_readout sa_assert u_assert (
    .clk               (clk),
    .channel_out_reset (channel_out_reset),
    .row_counter       (row_counter),
    .row_sel           (row_sel),
    .out               (out)
);

`default_nettype wire

// File: design/sa_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "sa_params.svh"

module sa_top (
    input  logic                             clk,
    input  logic                             channel_out_reset,
    input  logic                             en,
    input  readout_pkg::sa_mode_e            mode,
    input  logic                             acc_clear,
    input  logic                             channel_out_en,
    input  logic [8*`SA_ROWS-1:0]            row_in,
    input  logic [16*`SA_COLS-1:0]           column_in,
    output logic [readout_pkg::SA_OUT_W-1:0] out
);
    import pe_data_pkg::*;

    // skewed operands, feeder to array
    feed_if feed_bus ();

    // delayed clear strobe into every cell
    logic                      clear_q;
    // row access between array and readout
    logic [`SA_ROW_CNT_W-1:0]  row_sel;
    pe_result_u [`SA_COLS-1:0] row_results;

    operand_skew u_skew (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .en                (en),
        .mode              (mode),
        .acc_clear         (acc_clear),
        .row_in            (row_in),
        .column_in         (column_in),
        .feed              (feed_bus.src),
        .clear_q           (clear_q)
    );

    pe_array u_array (
        .clk         (clk),
        .feed        (feed_bus.dst),
        .clear       (clear_q),
        .row_sel     (row_sel),
        .row_results (row_results)
    );

    channel_readout u_readout (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .mode              (mode),
        .row_sel           (row_sel),
        .row_results       (row_results),
        .out               (out)
    );

endmodule

`default_nettype wire

// File: design/channel_readout.sv
`timescale 1ns/1ns
`default_nettype none

`include "sa_params.svh"

module channel_readout (
    input  logic                                   clk,
    input  logic                                   channel_out_reset,
    input  logic                                   channel_out_en,
    input  readout_pkg::sa_mode_e                  mode,
    output logic [`SA_ROW_CNT_W-1:0]               row_sel,
    input  pe_data_pkg::pe_result_u [`SA_COLS-1:0] row_results,
    output logic [readout_pkg::SA_OUT_W-1:0]       out
);
    import readout_pkg::*;

    // first code past the last row
    localparam logic [`SA_ROW_CNT_W-1:0] ROW_LIMIT = `SA_ROW_CNT_W'(`SA_ROWS);

    logic [`SA_ROW_CNT_W-1:0] row_counter;
    logic                     row_valid;

    ////////////////////////////////////////////////////////////
    // row counter
    ////////////////////////////////////////////////////////////
    // all ones means idle, first strobe wraps to row 0
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            row_counter <= '1;
        end else if (channel_out_en) begin
            row_counter <= row_counter + 1'b1;
        end
    end

    assign row_valid = (row_counter < ROW_LIMIT);
    // park on row 0 while idle
    assign row_sel   = row_valid ? row_counter : '0;

    ////////////////////////////////////////////////////////////
    // output formatting
    ////////////////////////////////////////////////////////////
    always_comb begin
        out = '0;
        if (row_valid) begin
            for (int j = 0; j < `SA_COLS; j++) begin
                if (mode == MODE_8X8) begin
                    // acc_lo low, acc_hi above it, upper bits stay zero
                    out[SA_SLOT88_W*j +: SA_SLOT88_W] =
                        {row_results[j].acc88.acc_hi, row_results[j].acc88.acc_lo};
                end else begin
                    // weight bit 0 sums in lower half
                    out[SA_SLOT18_W*j +: SA_SLOT18_W] = row_results[j].acc18[0];
                    // weight bit 1 sums in upper half
                    out[SA_HALF_W + SA_SLOT18_W*j +: SA_SLOT18_W] =
                        row_results[j].acc18[1];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pe_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "sa_params.svh"

module pe_array (
    input  logic                                   clk,
    feed_if.dst                                    feed,
    input  logic                                   clear,
    input  logic [`SA_ROW_CNT_W-1:0]               row_sel,
    output pe_data_pkg::pe_result_u [`SA_COLS-1:0] row_results
);
    import pe_data_pkg::*;

    // row index bits actually needed
    localparam int ROW_IDX_W = $clog2(`SA_ROWS);

    // horizontal links, spare column past the right edge
    logic        h_en [`SA_ROWS][`SA_COLS+1];
    weight_t     h_w  [`SA_ROWS][`SA_COLS+1];
    // vertical links, spare row below the bottom edge
    pixel_pair_t v_px [`SA_ROWS+1][`SA_COLS];
    // all cell results grouped by row
    pe_result_u [`SA_COLS-1:0] grid_res [`SA_ROWS];

    ////////////////////////////////////////////////////////////
    // array edges
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `SA_ROWS; i++) begin : g_left
        assign h_en[i][0] = feed.en[i];
        assign h_w[i][0]  = feed.weight[i];
    end

    for (genvar j = 0; j < `SA_COLS; j++) begin : g_top
        assign v_px[0][j] = feed.pixels[j];
    end

    ////////////////////////////////////////////////////////////
    // cell grid
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `SA_ROWS; i++) begin : g_row
        for (genvar j = 0; j < `SA_COLS; j++) begin : g_col
            pe u_pe (
                .clk      (clk),
                .clear    (clear),
                .mode     (feed.mode),
                .left_en  (h_en[i][j]),
                .left     (h_w[i][j]),
                .up       (v_px[i][j]),
                .right_en (h_en[i][j+1]),
                .right    (h_w[i][j+1]),
                .bottom   (v_px[i+1][j]),
                .result   (grid_res[i][j])
            );
        end
    end

    // readout keeps row_sel in range
    assign row_results = grid_res[row_sel[ROW_IDX_W-1:0]];

endmodule

`default_nettype wire

// File: design/pe.sv
`timescale 1ns/1ns
`default_nettype none

`include "sa_params.svh"

module pe (
    input  logic                     clk,
    input  logic                     clear,
    input  readout_pkg::sa_mode_e    mode,
    input  logic                     left_en,
    input  pe_data_pkg::weight_t     left,
    input  pe_data_pkg::pixel_pair_t up,
    output logic                     right_en,
    output pe_data_pkg::weight_t     right,
    output pe_data_pkg::pixel_pair_t bottom,
    output pe_data_pkg::pe_result_u  result
);
    import readout_pkg::*;

    // 8x8 products sign extended to accumulator width
    logic signed [`SA_ACC88_W-1:0] prod_lo;
    logic signed [`SA_ACC88_W-1:0] prod_hi;
    // pixels sign extended for the 1x8 sums
    // index 0 holds the lo pixel
    logic [1:0][`SA_ACC18_W-1:0]   px_ext;

    ////////////////////////////////////////////////////////////
    // operand forwarding
    ////////////////////////////////////////////////////////////
    // weight and en go right and pixels go down
    always_ff @(posedge clk) begin
        right_en <= left_en;
        right    <= left;
        bottom   <= up;
    end

    always_comb begin
        prod_lo   = left * up.lo;
        prod_hi   = left * up.hi;
        px_ext[0] = {{(`SA_ACC18_W-8){up.lo[7]}}, up.lo};
        px_ext[1] = {{(`SA_ACC18_W-8){up.hi[7]}}, up.hi};
    end

    ////////////////////////////////////////////////////////////
    // accumulation
    ////////////////////////////////////////////////////////////
    // clear wins over a live operand
    always_ff @(posedge clk) begin
        if (clear) begin
            result <= '0;
        end else if (left_en) begin
            case (mode)
                MODE_8X8: begin
                    result.acc88.acc_lo <= result.acc88.acc_lo + prod_lo;
                    result.acc88.acc_hi <= result.acc88.acc_hi + prod_hi;
                end
                MODE_1X8: begin
                    // weight bit b gates both pixels into row b of sums
                    for (int b = 0; b < 2; b++) begin
                        for (int k = 0; k < 2; k++) begin
                            if (left[b]) begin
                                result.acc18[b][k] <= result.acc18[b][k] + px_ext[k];
                            end
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/operand_skew.sv
`timescale 1ns/1ns
`default_nettype none

`include "sa_params.svh"

module operand_skew (
    input  logic                                    clk,
    input  logic                                    channel_out_reset,
    input  logic                                    en,
    input  readout_pkg::sa_mode_e                   mode,
    input  logic                                    acc_clear,
    input  pe_data_pkg::weight_t [`SA_ROWS-1:0]     row_in,
    input  pe_data_pkg::pixel_pair_t [`SA_COLS-1:0] column_in,
    feed_if.src                                     feed,
    output logic                                    clear_q
);
    import pe_data_pkg::*;

    // clear strobe takes one stage
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            clear_q <= 1'b0;
        end else begin
            clear_q <= acc_clear;
        end
    end

    // mode is a level, one stage as well
    always_ff @(posedge clk) begin
        feed.mode <= mode;
    end

    ////////////////////////////////////////////////////////////
    // row lanes
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `SA_ROWS; i++) begin : g_row
        // row i is 1+i stages deep
        logic [i:0]    en_pipe;
        weight_t [i:0] w_pipe;

        // en stages cleared so nothing accumulates after reset
        always_ff @(posedge clk) begin
            if (channel_out_reset) begin
                en_pipe <= '0;
            end else begin
                en_pipe[0] <= en;
                for (int s = 1; s <= i; s++) begin
                    en_pipe[s] <= en_pipe[s-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            w_pipe[0] <= row_in[i];
            for (int s = 1; s <= i; s++) begin
                w_pipe[s] <= w_pipe[s-1];
            end
        end

        // last tap feeds column 0 of the array
        assign feed.en[i]     = en_pipe[i];
        assign feed.weight[i] = w_pipe[i];
    end

    ////////////////////////////////////////////////////////////
    // column lanes
    ////////////////////////////////////////////////////////////
    for (genvar j = 0; j < `SA_COLS; j++) begin : g_col
        // column j is 1+j stages deep
        pixel_pair_t [j:0] px_pipe;

        always_ff @(posedge clk) begin
            px_pipe[0] <= column_in[j];
            for (int s = 1; s <= j; s++) begin
                px_pipe[s] <= px_pipe[s-1];
            end
        end

        assign feed.pixels[j] = px_pipe[j];
    end

endmodule

`default_nettype wire

// File: design/feed_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "sa_params.svh"

interface feed_if;
    import pe_data_pkg::*;
    import readout_pkg::*;

    // per row valid level, travels with that row's weight
    logic [`SA_ROWS-1:0]        en;
    // skewed weight byte per row
    weight_t [`SA_ROWS-1:0]     weight;
    // skewed pixel pair per column
    pixel_pair_t [`SA_COLS-1:0] pixels;
    // registered mode, common to all cells
    sa_mode_e                   mode;

    // feeder side
    modport src (output en, output weight, output pixels, output mode);
    // array side
    modport dst (input en, input weight, input pixels, input mode);

endinterface

`default_nettype wire

// File: design/readout_pkg.sv
`default_nettype none

`include "sa_params.svh"

package readout_pkg;

    // array operating mode
    typedef enum logic {
        MODE_8X8 = 1'b0,
        MODE_1X8 = 1'b1
    } sa_mode_e;

    // one column slot per mode
    localparam int SA_SLOT88_W = 2 * `SA_ACC88_W;
    localparam int SA_SLOT18_W = 2 * `SA_ACC18_W;

    // 1x8 output splits in two halves, one per weight bit
    localparam int SA_HALF_W = `SA_COLS * SA_SLOT18_W;
    // full readout word
    localparam int SA_OUT_W  = 2 * SA_HALF_W;

endpackage

`default_nettype wire

// File: design/pe_data_pkg.sv
`default_nettype none

`include "sa_params.svh"

package pe_data_pkg;

    // signed weight byte entering each row
    typedef logic signed [7:0] weight_t;

    // two signed pixels share one column word
    typedef struct packed {
        logic signed [7:0] hi;
        logic signed [7:0] lo;
    } pixel_pair_t;

    // result word size set by the four 1x8 sums
    localparam int PE_RESULT_W = 4 * `SA_ACC18_W;

    // 8x8 view
    // zero pad sits above the two accumulators
    typedef struct packed {
        logic [PE_RESULT_W-2*`SA_ACC88_W-1:0] pad;
        logic signed [`SA_ACC88_W-1:0]        acc_hi;
        logic signed [`SA_ACC88_W-1:0]        acc_lo;
    } acc88_t;

    // 1x8 view indexed [weight bit][pixel]
    typedef logic [1:0][1:0][`SA_ACC18_W-1:0] acc18_t;

    // same register bits read either way
    typedef union packed {
        acc88_t acc88;
        acc18_t acc18;
    } pe_result_u;

endpackage

`default_nettype wire

// File: design/sa_params.svh
`ifndef SA_PARAMS_SVH
`define SA_PARAMS_SVH

// array geometry
// rows take weights, columns take pixel pairs
`define SA_ROWS 4
`define SA_COLS 4

// accumulator widths per mode
// 8x8 mode keeps two wide signed sums
`define SA_ACC88_W 24
// 1x8 mode keeps four narrow wrapping sums
`define SA_ACC18_W 16

// readout counter wide enough for SA_ROWS plus the idle code
`define SA_ROW_CNT_W 3

`endif
